/* Makefile */
# Verilator build and run for the lsab_cr testbench

VERILATOR ?= verilator
TOP       ?= tb_lsab_cr
FILELIST  ?= lsab_cr.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) $(VFLAGS)

test: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/lsab_lane_if.sv */
`timescale 1ns/100ps

interface lsab_lane_if import lsab_pkg::*; ();

  logic  wr_req;    // decoded write strobe
  logic  rd_req;    // decoded read strobe
  logic  int_in;
  logic  careof;

  logic  do_write;  // accepted write
  logic  do_read;   // accepted read
  slot_t wr_slot;
  slot_t rd_slot;
  logic  empty;
  logic  stop;

  modport feed (
    output wr_req,
    output rd_req,
    output int_in,
    output careof,
    input  do_write,
    input  wr_slot
  );

  modport lane (
    input  wr_req,
    input  rd_req,
    input  int_in,
    input  careof,
    output do_write,
    output do_read,
    output wr_slot,
    output rd_slot,
    output empty,
    output stop
  );

  modport drain (
    input do_read,
    input rd_slot
  );

endinterface

/* common/lsab_pkg.sv */
package lsab_pkg;

  localparam int lane_count    = 4;
  localparam int slot_bits     = 6;
  localparam int lane_bits     = 2;
  localparam int data_bits     = 32;
  localparam int lane_capacity = 63;  // one slot kept free
  localparam int marker_depth  = 4;   // one entry is the gap
  localparam int addr_bits     = lane_bits + slot_bits;
  localparam int ram_words     = 1 << addr_bits;

  typedef logic [data_bits-1:0] data_t;

  typedef logic [slot_bits-1:0] slot_t;

  typedef logic [lane_bits-1:0] lane_sel_t;

  typedef logic [lane_count-1:0] lane_vec_t;

  typedef logic [$clog2(marker_depth)-1:0] marker_ptr_t;

  typedef struct packed {
    lane_sel_t lane;  // region select
    slot_t     slot;
  } lane_slot_t;

  // memory address seen flat or split by lane region
  typedef union packed {
    logic [addr_bits-1:0] flat;
    lane_slot_t           pair;
  } ram_addr_u;

endpackage

/* hdl/lsab_cr.sv */
`timescale 1ns/100ps

module lsab_cr import lsab_pkg::*; (
  input  logic      CLK,
  input  logic      RST,
  input  logic      read,
  input  logic      write,
  input  lane_sel_t read_fifo,
  input  lane_sel_t write_fifo,
  input  data_t     in_data [lane_count],
  input  lane_vec_t int_in,
  input  lane_vec_t careof_int,
  output data_t     out,
  output lane_vec_t empty,
  output lane_vec_t stop
);

  logic      mem_we;
  ram_addr_u mem_waddr;
  data_t     mem_wdata;

  lsab_lane_if lane_if [lane_count] ();

  lsab_write_mux i_write_mux (
    .read       (read),
    .write      (write),
    .write_fifo (write_fifo),
    .read_fifo  (read_fifo),
    .in_data    (in_data),
    .int_in     (int_in),
    .careof_int (careof_int),
    .lanes      (lane_if),
    .mem_we     (mem_we),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata)
  );

  for (genvar g = 0; g < lane_count; g++) begin : g_lane
    lsab_lane i_lane (
      .CLK  (CLK),
      .RST  (RST),
      .lane (lane_if[g])
    );

    assign empty[g] = lane_if[g].empty;
    assign stop[g]  = lane_if[g].stop;
  end

  lsab_read_port i_read_port (
    .CLK       (CLK),
    .RST       (RST),
    .read_fifo (read_fifo),
    .lanes     (lane_if),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .out       (out)
  );

endmodule

/* hdl/lsab_read_port.sv */
`timescale 1ns/100ps

module lsab_read_port import lsab_pkg::*; (
  input  logic       CLK,
  input  logic       RST,
  input  lane_sel_t  read_fifo,
  lsab_lane_if.drain lanes [lane_count],
  input  logic       mem_we,
  input  ram_addr_u  mem_waddr,
  input  data_t      mem_wdata,
  output data_t      out
);

  data_t     mem [ram_words];
  data_t     rdata;
  slot_t     rd_slots [lane_count];
  lane_vec_t do_read_vec;
  ram_addr_u raddr;
  logic      re;
  logic      re_q;

  for (genvar g = 0; g < lane_count; g++) begin : g_drain
    assign rd_slots[g]    = lanes[g].rd_slot;
    assign do_read_vec[g] = lanes[g].do_read;
  end

  always_comb begin
    raddr.pair.lane = read_fifo;
    raddr.pair.slot = rd_slots[read_fifo];
    re              = do_read_vec[read_fifo];
  end

  always_ff @(posedge CLK) begin
    if (mem_we) begin
      mem[mem_waddr.flat] <= mem_wdata;
    end
    if (re) begin
      rdata <= mem[raddr.flat];  // registered read
    end
  end

  // word lands on out one edge after the ram read
  always_ff @(posedge CLK) begin
    if (!RST) begin
      re_q <= 1'b0;
      out  <= '0;
    end else begin
      re_q <= re;
      if (re_q) begin
        out <= rdata;
      end
    end
  end

endmodule

/* hdl/lsab_write_mux.sv */
`timescale 1ns/100ps

module lsab_write_mux import lsab_pkg::*; (
  input  logic       read,
  input  logic       write,
  input  lane_sel_t  write_fifo,
  input  lane_sel_t  read_fifo,
  input  data_t      in_data [lane_count],
  input  lane_vec_t  int_in,
  input  lane_vec_t  careof_int,
  lsab_lane_if.feed  lanes [lane_count],
  output logic       mem_we,
  output ram_addr_u  mem_waddr,
  output data_t      mem_wdata
);

  slot_t     wr_slots [lane_count];
  lane_vec_t do_write_vec;

  for (genvar g = 0; g < lane_count; g++) begin : g_feed
    assign lanes[g].wr_req = write && (write_fifo == lane_sel_t'(g));
    assign lanes[g].rd_req = read && (read_fifo == lane_sel_t'(g));
    assign lanes[g].int_in = int_in[g];
    assign lanes[g].careof = careof_int[g];

    // gather lane status for the write port mux
    assign wr_slots[g]     = lanes[g].wr_slot;
    assign do_write_vec[g] = lanes[g].do_write;
  end

  always_comb begin
    mem_waddr.pair.lane = write_fifo;
    mem_waddr.pair.slot = wr_slots[write_fifo];
    mem_wdata           = in_data[write_fifo];
    mem_we              = do_write_vec[write_fifo];  // already gated by full
  end

endmodule

/* lsab_cr.f */
common/lsab_pkg.sv
common/lsab_lane_if.sv
hdl/lsab_write_mux.sv
lsab_lane/lsab_int_marker.sv
lsab_lane/lsab_lane.sv
hdl/lsab_read_port.sv
hdl/lsab_cr.sv
test/tb_lsab_cr.sv

/* lsab_lane/lsab_int_marker.sv */
`timescale 1ns/100ps

module lsab_int_marker import lsab_pkg::*; (
  input  logic  CLK,
  input  logic  RST,
  input  logic  do_write,
  input  logic  do_read,
  input  logic  int_in,
  input  slot_t wr_slot,
  input  slot_t rd_slot,
  output logic  marked_read
);

  slot_t       ring [marker_depth];
  marker_ptr_t rd_ptr;
  marker_ptr_t rd_trail;   // always one behind rd_ptr
  marker_ptr_t wr_ptr;
  logic        ring_empty;
  logic        ring_full;

  assign ring_empty = (rd_ptr == wr_ptr);
  assign ring_full  = (rd_trail == wr_ptr);

  // head entry matches the slot being read out
  assign marked_read = do_read && !ring_empty && (ring[rd_ptr] == rd_slot);

  always_ff @(posedge CLK) begin
    if (!RST) begin
      rd_ptr   <= marker_ptr_t'(1);
      rd_trail <= '0;
      wr_ptr   <= marker_ptr_t'(1);
      for (int i = 0; i < marker_depth; i++) begin
        ring[i] <= '0;
      end
    end else begin
      if (marked_read) begin
        rd_ptr   <= rd_ptr + marker_ptr_t'(1);
        rd_trail <= rd_trail + marker_ptr_t'(1);
      end
      if (do_write && int_in && !ring_full) begin
        ring[wr_ptr] <= wr_slot;
        wr_ptr       <= wr_ptr + marker_ptr_t'(1);
      end
    end
  end

endmodule

/* lsab_lane/lsab_lane.sv */
`timescale 1ns/100ps

module lsab_lane import lsab_pkg::*; (
  input logic       CLK,
  input logic       RST,
  lsab_lane_if.lane lane
);

  slot_t len;
  slot_t len_next;
  slot_t wr_ptr;
  slot_t rd_ptr;
  logic  full;
  logic  full_next;
  logic  empty_q;
  logic  empty_next;
  logic  stop_q;
  logic  stop_next;
  logic  marked_read;

  assign lane.do_write = lane.wr_req && !full;
  assign lane.do_read  = lane.rd_req && !stop_q;  // stop covers empty too
  assign lane.wr_slot  = wr_ptr;
  assign lane.rd_slot  = rd_ptr;
  assign lane.empty    = empty_q;
  assign lane.stop     = stop_q;

  // flags only move at the length boundaries
  always_comb begin
    len_next   = len;
    full_next  = full;
    empty_next = empty_q;
    case ({lane.do_read, lane.do_write})
      2'b01: begin
        len_next   = len + slot_t'(1);
        full_next  = (len == slot_t'(lane_capacity - 1));
        empty_next = 1'b0;
      end
      2'b10: begin
        len_next   = len - slot_t'(1);
        full_next  = 1'b0;
        empty_next = (len == slot_t'(1));
      end
      default: ;  // length holds on both or neither
    endcase
  end

  assign stop_next = empty_next || (marked_read && lane.careof);

  always_ff @(posedge CLK) begin
    if (!RST) begin
      len     <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      full    <= 1'b0;
      empty_q <= 1'b1;
      stop_q  <= 1'b1;
    end else begin
      len     <= len_next;
      full    <= full_next;
      empty_q <= empty_next;
      stop_q  <= stop_next;
      if (lane.do_write) begin
        wr_ptr <= wr_ptr + slot_t'(1);
      end
      if (lane.do_read) begin
        rd_ptr <= rd_ptr + slot_t'(1);
      end
    end
  end

  lsab_int_marker i_int_marker (
    .CLK         (CLK),
    .RST         (RST),
    .do_write    (lane.do_write),
    .do_read     (lane.do_read),
    .int_in      (lane.int_in),
    .wr_slot     (wr_ptr),
    .rd_slot     (rd_ptr),
    .marked_read (marked_read)
  );

endmodule

/* test/lsab_cr_tests.txt */
// columns: test(2) op(1) write lane(1) read lane(1) int(1) care(1) data(8), hex
// op: 0 idle, 1 write, 2 read, 3 write+read, 4 fill n, 5 drain n, 6 flags {stop,empty}, f end
// test 1, reset state, reads on empty lanes are ignored
01_6_0_0_0_0_000000ff
01_2_0_0_0_0_00000000
01_2_0_3_0_0_00000000
01_0_0_0_0_0_00000000
01_0_0_0_0_0_00000000
01_6_0_0_0_0_000000ff
// test 2, word order on lane 1
02_1_1_0_0_0_a1000001
02_6_0_0_0_0_000000dd
02_1_1_0_0_0_a1000002
02_1_1_0_0_0_a1000003
02_1_1_0_0_0_a1000004
02_5_0_1_0_0_00000004
02_0_0_0_0_0_00000000
02_0_0_0_0_0_00000000
02_6_0_0_0_0_000000ff
// test 3, lanes 0 and 3 interleaved, same cycle traffic
03_1_0_0_0_0_b0000001
03_1_3_0_0_0_b3000001
03_3_0_3_0_0_b0000002
03_3_3_0_0_0_b3000002
03_6_0_0_0_0_00000066
03_2_0_0_0_0_00000000
03_2_0_3_0_0_00000000
03_1_0_0_0_0_b0000003
03_3_0_0_0_0_b0000004
03_2_0_0_0_0_00000000
03_0_0_0_0_0_00000000
03_0_0_0_0_0_00000000
03_6_0_0_0_0_000000ff
// test 4, 64 writes into lane 2, only 63 kept
04_4_2_0_0_0_00000040
04_6_0_0_0_0_000000bb
04_5_0_2_0_0_0000003f
04_2_0_2_0_0_00000000
04_0_0_0_0_0_00000000
04_0_0_0_0_0_00000000
04_6_0_0_0_0_000000ff
// test 5, marked word on lane 2 with care-of, read during the pulse is ignored
05_1_2_0_1_0_c2000001
05_1_2_0_0_0_c2000002
05_1_2_0_0_0_c2000003
05_2_0_2_0_1_00000000
05_6_0_0_0_0_000000fb
05_2_0_2_0_1_00000000
05_6_0_0_0_0_000000bb
05_5_0_2_0_1_00000002
05_0_0_0_0_0_00000000
05_0_0_0_0_0_00000000
05_6_0_0_0_0_000000ff
// test 6, marked word on lane 1 with care-of low, no pulse
06_1_1_0_1_0_d1000001
06_1_1_0_0_0_d1000002
06_2_0_1_0_0_00000000
06_6_0_0_0_0_000000dd
06_2_0_1_0_0_00000000
06_0_0_0_0_0_00000000
06_0_0_0_0_0_00000000
06_6_0_0_0_0_000000ff
00_f_0_0_0_0_00000000

/* test/tb_lsab_cr.sv */
`timescale 1ns/100ps

module tb_lsab_cr import lsab_pkg::*; ();

  localparam int reset_cycles = 10;
  localparam int max_cmds     = 128;

  logic      CLK;
  logic      RST;
  logic      read;
  logic      write;
  lane_sel_t read_fifo;
  lane_sel_t write_fifo;
  data_t     in_data [lane_count];
  lane_vec_t int_in;
  lane_vec_t careof_int;
  data_t     out;
  lane_vec_t empty;
  lane_vec_t stop;

  logic [59:0] cmds [max_cmds];  // test, op, wlane, rlane, int, care, data
  int          cmd_count;
  int          cycle_limit = 0;
  int          cycles = 0;
  int          errors;
  int          tests_run;
  int          tests_failed;

  // reference model state
  data_t     model_q [lane_count][$];
  slot_t     model_marks [lane_count][$];
  slot_t     model_wr_slot [lane_count];
  slot_t     model_rd_slot [lane_count];
  lane_vec_t model_empty;
  lane_vec_t model_stop;
  data_t     model_rdata;
  data_t     model_out;
  logic      model_re_q;

  lsab_cr i_dut (
    .CLK        (CLK),
    .RST        (RST),
    .read       (read),
    .write      (write),
    .read_fifo  (read_fifo),
    .write_fifo (write_fifo),
    .in_data    (in_data),
    .int_in     (int_in),
    .careof_int (careof_int),
    .out        (out),
    .empty      (empty),
    .stop       (stop)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the test sequence did not finish", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  task automatic check_data(input data_t actual, input data_t expected, input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s is %h, expected %h", $time, what, actual, expected);
      errors++;
    end
  endtask

  task automatic check_flags(input lane_vec_t actual, input lane_vec_t expected,
                             input string what);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s is %b, expected %b", $time, what, actual, expected);
      errors++;
    end
  endtask

  // fill and drain take one cycle per word
  function automatic int cmd_cycles(input logic [59:0] cmd);
    if (cmd[51:48] == 4'h4 || cmd[51:48] == 4'h5) begin
      return int'(cmd[31:0]);
    end
    return 1;
  endfunction

  task automatic load_tests();
    int total;
    total     = 0;
    cmd_count = -1;
    $readmemh("test/lsab_cr_tests.txt", cmds);
    for (int i = 0; i < max_cmds; i++) begin
      if ($isunknown(cmds[i])) begin
        break;
      end
      if (cmds[i][51:48] == 4'hf) begin
        cmd_count = i;
        break;
      end
      total += cmd_cycles(cmds[i]);
    end
    cycle_limit = total * 4 + reset_cycles;
  endtask

  task automatic reset_model();
    for (int i = 0; i < lane_count; i++) begin
      model_q[i].delete();
      model_marks[i].delete();
      model_wr_slot[i] = '0;
      model_rd_slot[i] = '0;
    end
    model_empty = '1;
    model_stop  = '1;
    model_rdata = '0;
    model_out   = '0;
    model_re_q  = 1'b0;
  endtask

  // drive at the falling edge, update model at the rising edge, compare at the next fall
  task automatic run_cycle(input logic wr_en, input lane_sel_t wl, input data_t wd,
                           input logic wi, input logic rd_en, input lane_sel_t rl,
                           input logic care);
    logic wr_ok;
    logic rd_ok;
    logic marked;
    logic keep_mark;
    write          = wr_en;
    write_fifo     = wl;
    in_data[wl]    = wd;
    int_in         = '0;
    int_in[wl]     = wi;
    read           = rd_en;
    read_fifo      = rl;
    careof_int     = '0;
    careof_int[rl] = care;
    wr_ok     = wr_en && (model_q[wl].size() < lane_capacity);  // full drops it
    rd_ok     = rd_en && !model_stop[rl];
    marked    = rd_ok && (model_marks[rl].size() > 0) &&
                (model_marks[rl][0] == model_rd_slot[rl]);
    keep_mark = wr_ok && wi && (model_marks[wl].size() < marker_depth - 1);
    @(posedge CLK);
    if (model_re_q) begin
      model_out = model_rdata;
    end
    model_re_q = rd_ok;
    if (rd_ok) begin
      model_rdata       = model_q[rl].pop_front();
      model_rd_slot[rl] = model_rd_slot[rl] + slot_t'(1);
    end
    if (marked) begin
      model_marks[rl].delete(0);
    end
    if (keep_mark) begin
      model_marks[wl].push_back(model_wr_slot[wl]);
    end
    if (wr_ok) begin
      model_q[wl].push_back(wd);
      model_wr_slot[wl] = model_wr_slot[wl] + slot_t'(1);
    end
    for (int i = 0; i < lane_count; i++) begin
      model_empty[i] = (model_q[i].size() == 0);
      model_stop[i]  = model_empty[i];
    end
    if (marked && care) begin
      model_stop[rl] = 1'b1;  // one cycle pause
    end
    @(negedge CLK);
    check_data(out, model_out, "out");
    check_flags(empty, model_empty, "empty");
    check_flags(stop, model_stop, "stop");
  endtask

  task automatic run_command(input logic [59:0] cmd, input int index);
    lane_sel_t wl;
    lane_sel_t rl;
    logic      wi;
    logic      care;
    data_t     arg;
    wl   = cmd[45:44];
    rl   = cmd[41:40];
    wi   = cmd[36];
    care = cmd[32];
    arg  = cmd[31:0];
    case (cmd[51:48])
      4'h0: run_cycle(1'b0, wl, '0, 1'b0, 1'b0, rl, 1'b0);
      4'h1: run_cycle(1'b1, wl, arg, wi, 1'b0, rl, 1'b0);
      4'h2: run_cycle(1'b0, wl, '0, 1'b0, 1'b1, rl, care);
      4'h3: run_cycle(1'b1, wl, arg, wi, 1'b1, rl, care);
      4'h4: begin
        repeat (int'(arg)) begin
          run_cycle(1'b1, wl, $urandom, 1'b0, 1'b0, rl, 1'b0);
        end
      end
      4'h5: begin
        repeat (int'(arg)) begin
          run_cycle(1'b0, wl, '0, 1'b0, 1'b1, rl, care);
        end
      end
      4'h6: begin
        check_flags(empty, arg[3:0], "empty");
        check_flags(stop, arg[7:4], "stop");
      end
      default: begin
        $display("bad line %0d in the test file, unknown operation %h", index, cmd[51:48]);
        errors++;
      end
    endcase
  endtask

  task automatic finish_test(input int id, input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d done, ok", id);
    end else begin
      tests_failed++;
      $display("test %0d done, %0d errors", id, errors - errors_before);
    end
  endtask

  initial begin
    logic [59:0] cmd;
    int          cur_test;
    int          test_errors;
    void'($urandom(49420));
    RST        = 1'b0;
    read       = 1'b0;
    write      = 1'b0;
    read_fifo  = '0;
    write_fifo = '0;
    int_in     = '0;
    careof_int = '0;
    for (int i = 0; i < lane_count; i++) begin
      in_data[i] = '0;
    end
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    test_errors  = 0;
    load_tests();
    reset_model();
    repeat (reset_cycles) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b1;
    if (cmd_count < 0) begin
      $display("test file has no end command or holds an unreadable line");
      errors++;
    end
    cur_test = -1;
    for (int n = 0; n < cmd_count; n++) begin
      cmd = cmds[n];
      if (int'(cmd[59:52]) != cur_test) begin
        if (cur_test >= 0) begin
          finish_test(cur_test, test_errors);
        end
        cur_test    = int'(cmd[59:52]);
        test_errors = errors;
      end
      run_command(cmd, n);
    end
    if (cur_test >= 0) begin
      finish_test(cur_test, test_errors);
    end
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
